// ==== include/attn_macros.svh ====
`ifndef ATTN_MACROS_SVH
`define ATTN_MACROS_SVH

// lanes per chunk, power of two
`define NUM_LANES 8

// one fixed-point value, signed Q3.12
`define DATA_WIDTH 16
`define FRAC_BITS 12

// chunks that make up one value column (32 elements)
`define CHUNKS 4

// output buffer geometry
`define BUF_DEPTH 16
`define BUF_AWIDTH 4

`endif

// ==== verilog/attn_pkg.sv ====
`default_nettype none

`include "attn_macros.svh"

package attn_pkg;

	typedef logic [`DATA_WIDTH-1:0] fx_t; // Q3.12 raw bits, sign in msb

	typedef logic [`NUM_LANES*`DATA_WIDTH-1:0] lane_vec_t; // lane 0 in low bits

	typedef logic [`BUF_AWIDTH-1:0] buf_addr_t;

	// per-item tag, {first, last}
	typedef logic [1:0] tag_t;

	typedef enum logic {
		IDLE,  // no column open
		ACCUM  // partial sum held
	} acc_state_t;

endpackage

`default_nettype wire

// ==== verilog/lane_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// products of the multiplier array on their way to the adder tree
interface lane_bus_if;

	attn_pkg::lane_vec_t prod; // one product per lane
	logic valid;               // aligned with prod
	logic first;               // first chunk of a column
	logic last;                // last chunk of a column

	modport src (
		output prod,
		output valid,
		output first,
		output last
	);

	modport dst (
		input prod,
		input valid,
		input first,
		input last
	);

endinterface

`default_nettype wire

// ==== verilog/lane_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "attn_macros.svh"

module lane_mul (
	input  logic          clk,
	input  attn_pkg::fx_t a,
	input  attn_pkg::fx_t b,
	output attn_pkg::fx_t c
);

	localparam int PROD_W = 2 * `DATA_WIDTH;
	localparam int SLICE_MSB = `FRAC_BITS + `DATA_WIDTH - 2; // bit 26 for Q3.12

	attn_pkg::fx_t a_mag_q;
	attn_pkg::fx_t b_mag_q;
	logic a_sign_q;
	logic b_sign_q;
	logic [PROD_W-1:0] prod_q;
	logic neg_q;
	attn_pkg::fx_t slice;

	always_ff @(posedge clk) begin
		a_mag_q <= a[`DATA_WIDTH-1] ? -a : a; // stage 1, magnitudes
		b_mag_q <= b[`DATA_WIDTH-1] ? -b : b;
		a_sign_q <= a[`DATA_WIDTH-1];
		b_sign_q <= b[`DATA_WIDTH-1];
		prod_q <= a_mag_q * b_mag_q; // stage 2, unsigned product
		neg_q <= a_sign_q ^ b_sign_q;
	end

	// drop the low fraction bits and the top integer bits, zero extend
	assign slice = attn_pkg::fx_t'(prod_q[SLICE_MSB:`FRAC_BITS]);
	assign c = neg_q ? -slice : slice;

endmodule

`default_nettype wire

// ==== verilog/vecmat_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "attn_macros.svh"

module vecmat_mul (
	input  logic                clk,
	input  logic                reset,
	input  attn_pkg::lane_vec_t vector, // softmax weights
	input  attn_pkg::lane_vec_t matrix, // value column chunk
	input  logic                in_valid,
	input  logic                in_first,
	input  logic                in_last,
	lane_bus_if.src             bus
);

	localparam int W = `DATA_WIDTH;

	wire attn_pkg::lane_vec_t prod;
	logic [1:0] valid_q;
	attn_pkg::tag_t tag_q [2];

	for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
		lane_mul u_mul (
			.clk (clk),
			.a   (vector[i*W +: W]),
			.b   (matrix[i*W +: W]),
			.c   (prod[i*W +: W])
		);
	end

	// match the two register stages of each lane
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			tag_q[0] <= '0;
			tag_q[1] <= '0;
		end else begin
			valid_q <= {valid_q[0], in_valid};
			tag_q[0] <= {in_first, in_last};
			tag_q[1] <= tag_q[0];
		end
	end

	assign bus.prod = prod;
	assign bus.valid = valid_q[1];
	assign bus.first = tag_q[1][1];
	assign bus.last = tag_q[1][0];

endmodule

`default_nettype wire

// ==== verilog/sum_tree.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "attn_macros.svh"

module sum_tree (
	input  logic          clk,
	input  logic          reset,
	lane_bus_if.dst       bus,
	output attn_pkg::fx_t sum,
	output logic          sum_valid,
	output logic          sum_first,
	output logic          sum_last
);

	localparam int N = `NUM_LANES;
	localparam int W = `DATA_WIDTH;
	localparam int LEVELS = $clog2(N);

	// heap layout: node i adds nodes 2i and 2i+1, node 1 is the root
	attn_pkg::fx_t node [1:N-1];
	logic [LEVELS-1:0] valid_q;
	attn_pkg::tag_t tag_q [LEVELS];

	for (genvar i = 1; i < N; i++) begin : g_node
		if (2 * i >= N) begin : g_first_level
			always_ff @(posedge clk) begin
				node[i] <= bus.prod[(2*i-N)*W +: W] + bus.prod[(2*i-N+1)*W +: W];
			end
		end else begin : g_upper_level
			always_ff @(posedge clk) begin
				node[i] <= node[2*i] + node[2*i+1]; // wraps mod 2^16
			end
		end
	end

	// valid and tags ride along, one stage per tree level
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			for (int k = 0; k < LEVELS; k++) begin
				tag_q[k] <= '0;
			end
		end else begin
			valid_q[0] <= bus.valid;
			tag_q[0] <= {bus.first, bus.last};
			for (int k = 1; k < LEVELS; k++) begin
				valid_q[k] <= valid_q[k-1];
				tag_q[k] <= tag_q[k-1];
			end
		end
	end

	assign sum = node[1];
	assign sum_valid = valid_q[LEVELS-1];
	assign sum_first = tag_q[LEVELS-1][1];
	assign sum_last = tag_q[LEVELS-1][0];

endmodule

`default_nettype wire

// ==== verilog/chunk_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module chunk_accum (
	input  logic          clk,
	input  logic          reset,
	input  attn_pkg::fx_t sum,
	input  logic          sum_valid,
	input  logic          sum_first,
	input  logic          sum_last,
	output logic          wr_en,
	output attn_pkg::fx_t wr_data
);

	attn_pkg::acc_state_t state_q;
	attn_pkg::fx_t total_q;
	attn_pkg::fx_t base;
	attn_pkg::fx_t next_total;

	// first restarts the column; a stray chunk in IDLE starts from zero too
	assign base = (sum_first || state_q == attn_pkg::IDLE) ? '0 : total_q;
	assign next_total = base + sum;

	always_ff @(posedge clk) begin
		if (reset) begin
			state_q <= attn_pkg::IDLE;
			wr_en <= 1'b0;
		end else begin
			wr_en <= sum_valid && sum_last; // one-cycle write strobe
			if (sum_valid) begin
				if (sum_last)
					state_q <= attn_pkg::IDLE;
				else
					state_q <= attn_pkg::ACCUM;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (sum_valid)
			total_q <= next_total;
		if (sum_valid && sum_last)
			wr_data <= next_total; // finished element
	end

endmodule

`default_nettype wire

// ==== verilog/result_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "attn_macros.svh"

module result_buffer (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wr_en,
	input  attn_pkg::fx_t         wr_data,
	input  attn_pkg::buf_addr_t   rd_addr,
	output attn_pkg::fx_t         rd_data,
	output logic [`BUF_AWIDTH:0]  count
);

	attn_pkg::fx_t mem [`BUF_DEPTH];
	attn_pkg::buf_addr_t wr_addr_q;

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr_q] <= wr_data;
		rd_data <= mem[rd_addr]; // registered read, old data on collision
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_addr_q <= '0;
			count <= '0;
		end else if (wr_en) begin
			if (wr_addr_q == `BUF_DEPTH - 1)
				wr_addr_q <= '0; // oldest entry gets overwritten
			else
				wr_addr_q <= wr_addr_q + 1'b1;
			if (count != `BUF_DEPTH)
				count <= count + 1'b1; // saturates when full
		end
	end

endmodule

`default_nettype wire

// ==== verilog/attn_weighted_sum.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "attn_macros.svh"

module attn_weighted_sum (
	input  logic                 clk,
	input  logic                 reset,
	input  attn_pkg::lane_vec_t  weights,
	input  attn_pkg::lane_vec_t  vcol,
	input  logic                 in_valid,
	input  logic                 in_first,
	input  logic                 in_last,
	output logic                 elem_valid,
	output attn_pkg::fx_t        elem_data,
	output logic [`BUF_AWIDTH:0] elem_count,
	input  attn_pkg::buf_addr_t  rd_addr,
	output attn_pkg::fx_t        rd_data
);

	lane_bus_if lane_bus ();

	attn_pkg::fx_t sum;
	logic sum_valid;
	logic sum_first;
	logic sum_last;

	vecmat_mul u_mul (
		.clk      (clk),
		.reset    (reset),
		.vector   (weights),
		.matrix   (vcol),
		.in_valid (in_valid),
		.in_first (in_first),
		.in_last  (in_last),
		.bus      (lane_bus)
	);

	sum_tree u_tree (
		.clk       (clk),
		.reset     (reset),
		.bus       (lane_bus),
		.sum       (sum),
		.sum_valid (sum_valid),
		.sum_first (sum_first),
		.sum_last  (sum_last)
	);

	// the write strobe doubles as the element output
	chunk_accum u_accum (
		.clk       (clk),
		.reset     (reset),
		.sum       (sum),
		.sum_valid (sum_valid),
		.sum_first (sum_first),
		.sum_last  (sum_last),
		.wr_en     (elem_valid),
		.wr_data   (elem_data)
	);

	result_buffer u_buf (
		.clk     (clk),
		.reset   (reset),
		.wr_en   (elem_valid),
		.wr_data (elem_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.count   (elem_count)
	);

endmodule

`default_nettype wire

// ==== testbench/attn_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "attn_macros.svh"

module attn_assert (
	input wire logic                 clk,
	input wire logic                 reset,
	input wire logic                 in_valid,
	input wire logic                 in_last,
	input wire logic                 elem_valid,
	input wire logic [`BUF_AWIDTH:0] elem_count
);

	// a closing chunk comes out as an element after the full pipeline depth
	property p_elem_latency;
		@(posedge clk) disable iff (reset)
			(in_valid && in_last) |-> ##6 elem_valid;
	endproperty

	// control outputs stay quiet once reset has been seen for a cycle
	property p_quiet_in_reset;
		@(posedge clk) (reset && $past(reset)) |-> (!elem_valid && elem_count == '0);
	endproperty

	property p_count_monotonic;
		@(posedge clk) disable iff (reset)
			!$past(reset) |-> (elem_count >= $past(elem_count));
	endproperty

	a_elem_latency: assert property (p_elem_latency)
		else $error("elem_valid missing 6 cycles after a last chunk");
	a_quiet_in_reset: assert property (p_quiet_in_reset)
		else $error("control output active during reset");
	a_count_monotonic: assert property (p_count_monotonic)
		else $error("elem_count decreased without reset");

endmodule

bind attn_weighted_sum attn_assert u_assert (
	.clk        (clk),
	.reset      (reset),
	.in_valid   (in_valid),
	.in_last    (in_last),
	.elem_valid (elem_valid),
	.elem_count (elem_count)
);

`default_nettype wire

// ==== testbench/tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "attn_macros.svh"

module tb_checker (
	input wire logic                 clk,
	input wire logic                 reset,
	input wire attn_pkg::lane_vec_t  weights,
	input wire attn_pkg::lane_vec_t  vcol,
	input wire logic                 in_valid,
	input wire logic                 in_first,
	input wire logic                 in_last,
	input wire logic                 dir_valid, // hand-worked value rides with the last chunk
	input wire attn_pkg::fx_t        dir_data,
	input wire logic                 elem_valid,
	input wire attn_pkg::fx_t        elem_data,
	input wire logic [`BUF_AWIDTH:0] elem_count,
	input wire logic                 rd_check,
	input wire attn_pkg::buf_addr_t  rd_addr,
	input wire attn_pkg::fx_t        rd_data,
	output int                       pending,
	output int                       errors,
	output int                       checks
);

	localparam int W = `DATA_WIDTH;

	attn_pkg::fx_t exp_q [$];     // model elements in write order
	logic dir_flag_q [$];
	attn_pkg::fx_t dir_q [$];
	attn_pkg::fx_t acc;
	logic open;                   // a column has been started
	attn_pkg::fx_t buf_img [`BUF_DEPTH];
	logic buf_ok [`BUF_DEPTH];
	int wptr;
	logic [`BUF_AWIDTH:0] count;
	logic cnt_check_q;
	logic rd_check_q;
	attn_pkg::buf_addr_t rd_addr_q;

	// sign-magnitude product, magnitude bits 26..12 kept
	function automatic attn_pkg::fx_t lane_product(input attn_pkg::fx_t a, input attn_pkg::fx_t b);
		logic [W-1:0] ma;
		logic [W-1:0] mb;
		logic [2*W-1:0] p;
		attn_pkg::fx_t s;
		ma = a[W-1] ? (~a + 1'b1) : a;
		mb = b[W-1] ? (~b + 1'b1) : b;
		p = ma * mb;
		s = {1'b0, p[`FRAC_BITS+W-2:`FRAC_BITS]};
		return (a[W-1] ^ b[W-1]) ? (~s + 1'b1) : s;
	endfunction

	function automatic attn_pkg::fx_t chunk_sum(input attn_pkg::lane_vec_t w,
		input attn_pkg::lane_vec_t v);
		attn_pkg::fx_t s;
		s = '0;
		for (int i = 0; i < `NUM_LANES; i++) begin
			s = s + lane_product(w[i*W +: W], v[i*W +: W]); // wraps mod 2^16
		end
		return s;
	endfunction

	task automatic mismatch(input string sig, input logic [W-1:0] e, input logic [W-1:0] g);
		errors++;
		$display("CHECK FAILED at %0d ns: %s expected %h, got %h", $time, sig, e, g);
	endtask

	initial begin
		errors = 0;
		checks = 0;
		pending = 0;
	end

	always @(negedge clk) begin
		attn_pkg::fx_t s;
		attn_pkg::fx_t e;
		logic d;
		attn_pkg::fx_t de;
		if (reset) begin
			exp_q.delete(); // flushed along with the pipeline
			dir_flag_q.delete();
			dir_q.delete();
			open = 1'b0;
			acc = '0;
			wptr = 0;
			count = '0;
			cnt_check_q = 1'b0;
			rd_check_q = 1'b0;
			for (int k = 0; k < `BUF_DEPTH; k++) begin
				buf_ok[k] = 1'b0;
			end
		end else begin
			// count moves on the write edge, one cycle after elem_valid shows
			if (cnt_check_q) begin
				checks++;
				if (elem_count !== count)
					mismatch("elem_count", count, elem_count);
			end
			cnt_check_q = 1'b0;
			if (in_valid) begin
				s = chunk_sum(weights, vcol);
				if (in_first || !open)
					acc = s;
				else
					acc = acc + s;
				open = !in_last;
				if (in_last) begin
					exp_q.push_back(acc);
					dir_flag_q.push_back(dir_valid);
					dir_q.push_back(dir_data);
				end
			end
			if (elem_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("error at %0d ns: elem_valid pulsed with no element pending", $time);
				end else begin
					e = exp_q.pop_front();
					d = dir_flag_q.pop_front();
					de = dir_q.pop_front();
					checks++;
					if (elem_data !== e)
						mismatch("elem_data", e, elem_data);
					if (d && elem_data !== de)
						mismatch("elem_data (worked value)", de, elem_data);
					buf_img[wptr] = e;
					buf_ok[wptr] = 1'b1;
					wptr = (wptr + 1) % `BUF_DEPTH;
					count = (count == (`BUF_AWIDTH+1)'(`BUF_DEPTH)) ? count : count + 1'b1;
					cnt_check_q = 1'b1;
				end
			end
			if (rd_check_q && buf_ok[rd_addr_q]) begin
				checks++;
				if (rd_data !== buf_img[rd_addr_q])
					mismatch("rd_data", buf_img[rd_addr_q], rd_data);
			end
			rd_check_q = rd_check;
			rd_addr_q = rd_addr;
		end
		pending = exp_q.size();
	end

endmodule

`default_nettype wire

// ==== testbench/tb_attn.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "attn_macros.svh"

module tb_attn;

	localparam int W = `DATA_WIDTH;

	logic clk;
	logic reset;
	attn_pkg::lane_vec_t weights;
	attn_pkg::lane_vec_t vcol;
	logic in_valid;
	logic in_first;
	logic in_last;
	logic elem_valid;
	attn_pkg::fx_t elem_data;
	logic [`BUF_AWIDTH:0] elem_count;
	attn_pkg::buf_addr_t rd_addr;
	attn_pkg::fx_t rd_data;
	logic dir_valid;
	attn_pkg::fx_t dir_data;
	logic rd_check;
	int pending;
	int errors;
	int checks;
	int seed;
	logic timed_out;
	string timeout_reason;

	// stimulus table, one row per chunk
	attn_pkg::lane_vec_t row_w [$];
	attn_pkg::lane_vec_t row_v [$];
	logic row_f [$];
	logic row_l [$];
	logic row_d [$];            // row carries a worked expected element
	attn_pkg::fx_t row_e [$];
	int row_gap [$];            // idle cycles after the row

	attn_weighted_sum dut (
		.clk        (clk),
		.reset      (reset),
		.weights    (weights),
		.vcol       (vcol),
		.in_valid   (in_valid),
		.in_first   (in_first),
		.in_last    (in_last),
		.elem_valid (elem_valid),
		.elem_data  (elem_data),
		.elem_count (elem_count),
		.rd_addr    (rd_addr),
		.rd_data    (rd_data)
	);

	tb_checker chk (
		.clk (clk), .reset (reset), .weights (weights), .vcol (vcol),
		.in_valid (in_valid), .in_first (in_first), .in_last (in_last),
		.dir_valid (dir_valid), .dir_data (dir_data),
		.elem_valid (elem_valid), .elem_data (elem_data), .elem_count (elem_count),
		.rd_check (rd_check), .rd_addr (rd_addr), .rd_data (rd_data),
		.pending (pending), .errors (errors), .checks (checks)
	);

	always #10 clk = ~clk;

	function automatic attn_pkg::lane_vec_t rep(input attn_pkg::fx_t x);
		return {`NUM_LANES{x}};
	endfunction

	function automatic attn_pkg::lane_vec_t rand_vec();
		attn_pkg::lane_vec_t v;
		for (int i = 0; i < `NUM_LANES; i++) begin
			v[i*W +: W] = W'($random(seed));
		end
		return v;
	endfunction

	task automatic add_row(input attn_pkg::lane_vec_t w, input attn_pkg::lane_vec_t v,
		input logic f, input logic l, input logic d, input attn_pkg::fx_t e, input int gap);
		row_w.push_back(w);
		row_v.push_back(v);
		row_f.push_back(f);
		row_l.push_back(l);
		row_d.push_back(d);
		row_e.push_back(e);
		row_gap.push_back(gap);
	endtask

	task automatic idle_inputs();
		in_valid <= 1'b0;
		in_first <= 1'b0;
		in_last <= 1'b0;
		dir_valid <= 1'b0;
	endtask

	task automatic apply_table();
		for (int i = 0; i < row_w.size(); i++) begin
			@(posedge clk);
			weights <= row_w[i];
			vcol <= row_v[i];
			in_valid <= 1'b1;
			in_first <= row_f[i];
			in_last <= row_l[i];
			dir_valid <= row_d[i] && row_l[i];
			dir_data <= row_e[i];
			for (int g = 0; g < row_gap[i]; g++) begin
				@(posedge clk);
				idle_inputs();
			end
		end
		@(posedge clk);
		idle_inputs();
		row_w.delete();
		row_v.delete();
		row_f.delete();
		row_l.delete();
		row_d.delete();
		row_e.delete();
		row_gap.delete();
	endtask

	// wait until every expected element has come out
	task automatic wait_drain();
		int n;
		n = 0;
		while (pending != 0 && n < 100) begin
			@(posedge clk);
			n++;
		end
		if (pending != 0) begin
			timeout_reason = "elements still pending after 100 cycles";
			timed_out = 1'b1;
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic report(input int num, input string name);
		$display("test %0d %s done: %0d checks, %0d errors so far", num, name, checks, errors);
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		weights = '0;
		vcol = '0;
		in_valid = 1'b0;
		in_first = 1'b0;
		in_last = 1'b0;
		rd_addr = '0;
		dir_valid = 1'b0;
		dir_data = '0;
		rd_check = 1'b0;
		timed_out = 1'b0;
		seed = 32'hdb3b_1465;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		repeat (2) @(posedge clk);

		// 1.0 * 1.0 per lane, 8 lanes wrap to 0x8000
		add_row(rep(16'h1000), rep(16'h1000), 1'b1, 1'b1, 1'b1, 16'h8000, 0);
		add_row(rep(16'h0800), rep(16'h2000), 1'b1, 1'b1, 1'b1, 16'h8000, 2);
		add_row(rep(16'h0400), rep(16'h0400), 1'b1, 1'b1, 1'b1, 16'h0800, 1);
		for (int k = 0; k < 4; k++) begin
			add_row(rand_vec(), rand_vec(), 1'b1, 1'b1, 1'b0, '0, k);
		end
		apply_table();
		wait_drain();
		report(1, "single-chunk columns");

		for (int k = 0; k < `CHUNKS; k++) begin
			add_row(rep(16'h1000), rep(16'h0200), k == 0, k == `CHUNKS - 1, 1'b1, 16'h4000, 3);
		end
		for (int k = 0; k < `CHUNKS; k++) begin
			add_row(rand_vec(), rand_vec(), k == 0, k == `CHUNKS - 1, 1'b0, '0, k);
		end
		apply_table();
		wait_drain();
		report(2, "four-chunk columns");

		add_row({{4{16'h0000}}, {4{16'hf000}}}, rep(16'h1000), 1'b1, 1'b1, 1'b1, 16'hc000, 1);
		add_row(rep(16'he800), rep(16'h0c00), 1'b1, 1'b1, 1'b1, 16'h7000, 1); // -1.5 * 0.75
		add_row(rep(16'h1800), rep(16'hf400), 1'b1, 1'b1, 1'b1, 16'h7000, 1);
		apply_table();
		wait_drain();
		report(3, "sign handling");

		while (row_w.size() < 12) begin
			int len;
			len = ($random(seed) & 3) + 1;
			for (int k = 0; k < len; k++) begin
				add_row(rand_vec(), rand_vec(), k == 0, k == len - 1, 1'b0, '0, 0);
			end
		end
		apply_table();
		wait_drain();
		report(4, "back-to-back chunks");

		for (int k = 0; k < 20; k++) begin
			add_row(rand_vec(), rand_vec(), 1'b1, 1'b1, 1'b0, '0, 0);
		end
		apply_table();
		wait_drain();
		for (int k = 0; k < `BUF_DEPTH; k++) begin
			@(posedge clk);
			rd_check <= 1'b1;
			rd_addr <= attn_pkg::buf_addr_t'(k);
		end
		@(posedge clk);
		rd_check <= 1'b0;
		repeat (2) @(posedge clk);
		report(5, "buffer readback");

		// long gap so the partial sum is held in the accumulator at reset
		add_row(rand_vec(), rand_vec(), 1'b1, 1'b0, 1'b0, '0, 6);
		apply_table();
		@(posedge clk);
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		// a stray closing chunk starts from zero
		add_row(rep(16'h1000), rep(16'h1000), 1'b0, 1'b1, 1'b1, 16'h8000, 1);
		add_row(rep(16'h0400), rep(16'h0400), 1'b1, 1'b1, 1'b1, 16'h0800, 0);
		apply_table();
		wait_drain();
		report(6, "reset mid-column");

		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0 && !timed_out)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin : watchdog
		int n;
		for (n = 0; n < 20000 && !timed_out; n++) begin
			@(posedge clk);
		end
		if (!timed_out) begin
			timeout_reason = "simulation ran past the cycle limit";
			timed_out = 1'b1;
		end
	end

	initial begin
		wait (timed_out);
		$display("timeout: %s", timeout_reason);
		$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+include
verilog/attn_pkg.sv
verilog/lane_bus_if.sv
verilog/lane_mul.sv
verilog/vecmat_mul.sv
verilog/sum_tree.sv
verilog/chunk_accum.sv
verilog/result_buffer.sv
verilog/attn_weighted_sum.sv
testbench/attn_assert.sv
testbench/tb_checker.sv
testbench/tb_attn.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_attn
FILELIST  := filelist.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINTFLAGS := --lint-only --timing
BUILD     := obj_dir
LOG       := sim.log
PASS_MSG  := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
